/* design/arith_types_pkg.sv */
package arith_types_pkg;

  // one operand or result word
  localparam int data_width = 32;

  // one root bit per radicand bit pair
  localparam int sqrt_steps = data_width / 2;

  // operand, product and output registers
  localparam int mul_stages = 3;

  typedef logic [data_width-1:0] word_t;

  // root before zero extension to a word
  typedef logic [sqrt_steps-1:0] root_t;

endpackage

/* design/arith_ctrl_pkg.sv */
package arith_ctrl_pkg;

  typedef enum logic [1:0] {
    op_div  = 2'd0,
    op_mod  = 2'd1,
    op_mul  = 2'd2,
    op_sqrt = 2'd3
  } op_e;

  // shared by the top level and the iterative engines
  typedef enum logic {
    st_idle = 1'b0,
    st_busy = 1'b1
  } unit_state_e;

  typedef struct packed {
    op_e                    op;
    arith_types_pkg::word_t left;
    arith_types_pkg::word_t right;  // unused for sqrt
  } arith_req_t;

  typedef struct packed {
    arith_types_pkg::word_t result;
    logic                   div_by_zero;
  } arith_rsp_t;

endpackage

/* design/seq_divider.sv */
`timescale 1ns/1ps

module seq_divider (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  arith_types_pkg::word_t dividend,
  input  arith_types_pkg::word_t divisor,
  output logic                   done,
  output arith_types_pkg::word_t quotient,
  output arith_types_pkg::word_t remainder
);

  // divisor is shifted up by one word less one bit
  typedef logic [2*arith_types_pkg::data_width-2:0] wide_t;

  arith_ctrl_pkg::unit_state_e state;

  wide_t                  divisor_q;
  arith_types_pkg::word_t mask_q;   // quotient bit being decided
  logic                   start;
  logic                   last_step;
  logic                   fits;

  assign start     = go && (state == arith_ctrl_pkg::st_idle);
  assign last_step = mask_q[0];
  assign fits      = (divisor_q <= wide_t'(remainder));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= arith_ctrl_pkg::st_idle;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        arith_ctrl_pkg::st_idle: begin
          if (go) begin
            state <= arith_ctrl_pkg::st_busy;
          end
        end
        arith_ctrl_pkg::st_busy: begin
          // done comes with the final compare-subtract
          if (last_step) begin
            state <= arith_ctrl_pkg::st_idle;
            done  <= 1'b1;
          end
        end
      endcase
    end
  end

  // remainder register doubles as the running partial dividend
  always_ff @(posedge clk) begin
    if (start) begin
      remainder <= dividend;
      divisor_q <= {divisor, {(arith_types_pkg::data_width-1){1'b0}}};
      quotient  <= '0;
      mask_q    <= {1'b1, {(arith_types_pkg::data_width-1){1'b0}}};
    end else if (state == arith_ctrl_pkg::st_busy) begin
      if (fits) begin
        remainder <= remainder - divisor_q[arith_types_pkg::data_width-1:0];
        quotient  <= quotient | mask_q;
      end
      divisor_q <= divisor_q >> 1;
      mask_q    <= mask_q >> 1;
    end
  end

endmodule

/* design/pipe_multiplier.sv */
`timescale 1ns/1ps

module pipe_multiplier (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  arith_types_pkg::word_t left,
  input  arith_types_pkg::word_t right,
  output logic                   done,
  output arith_types_pkg::word_t product
);

  logic [arith_types_pkg::mul_stages-1:0] valid_q;

  arith_types_pkg::word_t left_q;
  arith_types_pkg::word_t right_q;
  arith_types_pkg::word_t prod_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[arith_types_pkg::mul_stages-2:0], go};
    end
  end

  assign done = valid_q[arith_types_pkg::mul_stages-1];

  // each stage only moves when its valid bit says so
  always_ff @(posedge clk) begin
    if (go) begin
      left_q  <= left;
      right_q <= right;
    end
    if (valid_q[0]) begin
      prod_q <= left_q * right_q;  // low word only
    end
    if (valid_q[1]) begin
      product <= prod_q;
    end
  end

endmodule

/* design/int_sqrt.sv */
`timescale 1ns/1ps

module int_sqrt (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  arith_types_pkg::word_t radicand,
  output logic                   done,
  output arith_types_pkg::root_t root
);

  typedef logic [$clog2(arith_types_pkg::sqrt_steps)-1:0] step_t;
  // two extra bits, msb is the sign
  typedef logic [arith_types_pkg::sqrt_steps+1:0] rem_t;

  localparam step_t last_cnt = step_t'(arith_types_pkg::sqrt_steps - 1);

  arith_ctrl_pkg::unit_state_e state;

  step_t                  step_cnt;
  arith_types_pkg::word_t rad_q;
  rem_t                   rem_q;
  rem_t                   trial;
  rem_t                   rem_next;

  // next bit pair appended to the shifted remainder
  always_comb begin
    trial = {rem_q[arith_types_pkg::sqrt_steps-1:0],
             rad_q[arith_types_pkg::data_width-1 -: 2]};
    if (rem_q[arith_types_pkg::sqrt_steps+1]) begin
      rem_next = trial + {root, 2'b11};  // negative, add back
    end else begin
      rem_next = trial - {root, 2'b01};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= arith_ctrl_pkg::st_idle;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        arith_ctrl_pkg::st_idle: begin
          step_cnt <= '0;
          if (go) begin
            state <= arith_ctrl_pkg::st_busy;
          end
        end
        arith_ctrl_pkg::st_busy: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == last_cnt) begin
            state <= arith_ctrl_pkg::st_idle;
            done  <= 1'b1;
          end
        end
      endcase
    end
  end

  // setup cycle on go, then one root bit per step
  always_ff @(posedge clk) begin
    if (go && state == arith_ctrl_pkg::st_idle) begin
      rad_q <= radicand;
      rem_q <= '0;
      root  <= '0;
    end else if (state == arith_ctrl_pkg::st_busy) begin
      rad_q <= rad_q << 2;
      rem_q <= rem_next;
      root  <= {root[arith_types_pkg::sqrt_steps-2:0],
                ~rem_next[arith_types_pkg::sqrt_steps+1]};
    end
  end

endmodule

/* design/arith_unit.sv */
`timescale 1ns/1ps

module arith_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  arith_ctrl_pkg::arith_req_t req,
  output logic                      busy,
  output logic                      done,
  output arith_ctrl_pkg::arith_rsp_t rsp
);

  arith_ctrl_pkg::unit_state_e state;
  arith_ctrl_pkg::arith_req_t  req_q;   // held for the whole operation
  arith_ctrl_pkg::arith_rsp_t  rsp_next;

  logic go_q;
  logic div_go;
  logic mul_go;
  logic sqrt_go;
  logic div_done;
  logic mul_done;
  logic sqrt_done;
  logic eng_done;
  logic divisor_zero;

  arith_types_pkg::word_t quotient;
  arith_types_pkg::word_t remainder;
  arith_types_pkg::word_t product;
  arith_types_pkg::root_t root;

  assign busy = (state == arith_ctrl_pkg::st_busy);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= arith_ctrl_pkg::st_idle;
      go_q  <= 1'b0;
      done  <= 1'b0;
      rsp   <= '0;
    end else begin
      go_q <= 1'b0;
      done <= 1'b0;
      case (state)
        arith_ctrl_pkg::st_idle: begin
          if (start) begin
            state <= arith_ctrl_pkg::st_busy;
            go_q  <= 1'b1;
          end
        end
        arith_ctrl_pkg::st_busy: begin
          if (eng_done) begin
            state <= arith_ctrl_pkg::st_idle;
            done  <= 1'b1;
            rsp   <= rsp_next;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && state == arith_ctrl_pkg::st_idle) begin
      req_q <= req;
    end
  end

  // dispatch to one engine
  assign div_go  = go_q && (req_q.op == arith_ctrl_pkg::op_div ||
                            req_q.op == arith_ctrl_pkg::op_mod);
  assign mul_go  = go_q && (req_q.op == arith_ctrl_pkg::op_mul);
  assign sqrt_go = go_q && (req_q.op == arith_ctrl_pkg::op_sqrt);

  assign divisor_zero = (req_q.right == '0);

  always_comb begin
    rsp_next.div_by_zero = 1'b0;
    case (req_q.op)
      arith_ctrl_pkg::op_div: begin
        rsp_next.result      = quotient;  // all ones on zero divisor
        rsp_next.div_by_zero = divisor_zero;
        eng_done             = div_done;
      end
      arith_ctrl_pkg::op_mod: begin
        rsp_next.result      = remainder;
        rsp_next.div_by_zero = divisor_zero;
        eng_done             = div_done;
      end
      arith_ctrl_pkg::op_mul: begin
        rsp_next.result = product;
        eng_done        = mul_done;
      end
      default: begin
        rsp_next.result = {{(arith_types_pkg::data_width-arith_types_pkg::sqrt_steps){1'b0}},
                           root};
        eng_done        = sqrt_done;
      end
    endcase
  end

  seq_divider seq_divider_i (
    .clk       (clk),
    .reset     (reset),
    .go        (div_go),
    .dividend  (req_q.left),
    .divisor   (req_q.right),
    .done      (div_done),
    .quotient  (quotient),
    .remainder (remainder)
  );

  pipe_multiplier pipe_multiplier_i (
    .clk     (clk),
    .reset   (reset),
    .go      (mul_go),
    .left    (req_q.left),
    .right   (req_q.right),
    .done    (mul_done),
    .product (product)
  );

  int_sqrt int_sqrt_i (
    .clk      (clk),
    .reset    (reset),
    .go       (sqrt_go),
    .radicand (req_q.left),
    .done     (sqrt_done),
    .root     (root)
  );

endmodule

/* test/arith_unit_checker.sv */
`timescale 1ns/1ps

module arith_unit_checker (
  input logic clk,
  input logic reset,
  input logic start,
  input logic busy,
  input logic done
);

  logic pending;  // accepted request still waiting for done

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (start && !busy) begin
      pending <= 1'b1;
    end else if (done) begin
      pending <= 1'b0;
    end
  end

  done_single_cycle: assert property (
    @(posedge clk) disable iff (reset) done |=> !done
  ) else $error("done held high for more than one cycle");

  busy_falls_with_done: assert property (
    @(posedge clk) disable iff (reset) $fell(busy) |-> done
  ) else $error("busy fell without done");

  // done only answers an earlier accept
  done_after_accept: assert property (
    @(posedge clk) disable iff (reset) done |-> pending
  ) else $error("done without an accepted request");

endmodule

bind arith_unit arith_unit_checker arith_unit_checker_i (
  .clk   (clk),
  .reset (reset),
  .start (start),
  .busy  (busy),
  .done  (done)
);

/* test/arith_unit_tb.sv */
`timescale 1ns/1ps

module arith_unit_tb;

  // ~190 requests at 34 cycles worst case, with margin
  localparam int timeout_cycles = 10000;
  localparam int mixed_ops      = 120;

  typedef logic [2*arith_types_pkg::data_width-1:0] dword_t;

  logic                       clk;
  logic                       reset;
  logic                       start;
  arith_ctrl_pkg::arith_req_t req;
  logic                       busy;
  logic                       done;
  arith_ctrl_pkg::arith_rsp_t rsp;

  logic [31:0] rng_state;
  int          cycles = 0;
  int          accepted = 0;
  int          done_count = 0;
  int          checks = 0;
  int          mismatches = 0;
  int          failures = 0;
  logic        prev_done = 1'b0;
  logic        prev_busy = 1'b0;

  arith_ctrl_pkg::arith_req_t req_fifo[$];  // accepted, not yet answered
  int                         acc_fifo[$];  // cycle of the accepting edge

  arith_unit arith_unit_i (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .req   (req),
    .busy  (busy),
    .done  (done),
    .rsp   (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("ERROR: run did not finish within %0d cycles", timeout_cycles);
      print_counts();
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_word(output arith_types_pkg::word_t w);
    rng_state = xorshift(rng_state);
    w = rng_state;
  endtask

  function automatic arith_ctrl_pkg::arith_rsp_t expected_rsp(
    input arith_ctrl_pkg::arith_req_t r
  );
    arith_ctrl_pkg::arith_rsp_t e;
    arith_types_pkg::word_t     root;
    arith_types_pkg::word_t     trial;
    dword_t                     full;
    e.result      = '0;
    e.div_by_zero = 1'b0;
    case (r.op)
      arith_ctrl_pkg::op_div: begin
        e.result      = (r.right == '0) ? '1 : r.left / r.right;
        e.div_by_zero = (r.right == '0);
      end
      arith_ctrl_pkg::op_mod: begin
        e.result      = (r.right == '0) ? r.left : r.left % r.right;
        e.div_by_zero = (r.right == '0);
      end
      arith_ctrl_pkg::op_mul: begin
        full     = dword_t'(r.left) * dword_t'(r.right);
        e.result = full[arith_types_pkg::data_width-1:0];
      end
      default: begin
        // largest root whose square still fits under left
        root = '0;
        for (int b = arith_types_pkg::sqrt_steps - 1; b >= 0; b--) begin
          trial = root | (arith_types_pkg::word_t'(1) << b);
          if (dword_t'(trial) * dword_t'(trial) <= dword_t'(r.left)) root = trial;
        end
        e.result = root;
      end
    endcase
    return e;
  endfunction

  function automatic int latency_of(input arith_ctrl_pkg::op_e op);
    case (op)
      arith_ctrl_pkg::op_mul:  return arith_types_pkg::mul_stages + 1;
      arith_ctrl_pkg::op_sqrt: return arith_types_pkg::sqrt_steps + 2;
      default:                 return arith_types_pkg::data_width + 2;
    endcase
  endfunction

  task automatic print_counts();
    $display("checks %0d, mismatches %0d, other errors %0d, requests %0d, done pulses %0d",
             checks, mismatches, failures, accepted, done_count);
  endtask

  task automatic check_result();
    arith_ctrl_pkg::arith_req_t r;
    arith_ctrl_pkg::arith_rsp_t exp;
    int                         lat;
    done_count++;
    if (req_fifo.size() == 0) begin
      failures++;
      $display("ERROR at %0t: done pulse with no request outstanding", $time);
    end else begin
      r   = req_fifo.pop_front();
      lat = cycles - acc_fifo.pop_front();
      exp = expected_rsp(r);
      checks++;
      if (rsp.result !== exp.result || rsp.div_by_zero !== exp.div_by_zero) begin
        mismatches++;
        $display("MISMATCH at %0t: op %s left %h right %h gave %h/%b, expected %h/%b",
                 $time, r.op.name(), r.left, r.right, rsp.result, rsp.div_by_zero,
                 exp.result, exp.div_by_zero);
      end
      if (lat != latency_of(r.op)) begin
        mismatches++;
        $display("MISMATCH at %0t: op %s done after %0d cycles, expected %0d",
                 $time, r.op.name(), lat, latency_of(r.op));
      end
    end
  endtask

  // outputs only move on the rising edge
  always @(negedge clk) begin
    if (!reset) begin
      if (done && prev_done) begin
        failures++;
        $display("ERROR at %0t: done stayed high for two cycles", $time);
      end
      if (prev_busy && !busy && !done) begin
        failures++;
        $display("ERROR at %0t: busy dropped without a done pulse", $time);
      end
      if (done) check_result();
    end
    prev_done = done;
    prev_busy = busy;
  end

  task automatic wait_idle();
    while (busy) @(negedge clk);
  endtask

  task automatic issue_op(input arith_ctrl_pkg::op_e op,
                          input arith_types_pkg::word_t left,
                          input arith_types_pkg::word_t right);
    wait_idle();
    start     = 1'b1;
    req.op    = op;
    req.left  = left;
    req.right = right;
    req_fifo.push_back(req);
    acc_fifo.push_back(cycles + 1);  // taken on the next rising edge
    accepted++;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic run_op(input arith_ctrl_pkg::op_e op,
                        input arith_types_pkg::word_t left,
                        input arith_types_pkg::word_t right);
    issue_op(op, left, right);
    wait_idle();
  endtask

  task automatic check_reset_values();
    checks++;
    if (busy !== 1'b0 || done !== 1'b0 || rsp !== '0) begin
      mismatches++;
      $display("MISMATCH at %0t: after reset busy %b done %b rsp %h, expected all zero",
               $time, busy, done, rsp);
    end
  endtask

  task automatic div_mod_tests();
    arith_types_pkg::word_t a;
    arith_types_pkg::word_t b;
    for (int i = 0; i < 16; i++) begin
      next_word(a);
      next_word(b);
      b = b >> a[4:0];  // spread divisor sizes
      run_op(i[0] ? arith_ctrl_pkg::op_mod : arith_ctrl_pkg::op_div, a, b);
    end
    next_word(a);
    run_op(arith_ctrl_pkg::op_div, a, '0);
    run_op(arith_ctrl_pkg::op_mod, a, '0);
    run_op(arith_ctrl_pkg::op_div, '0, '0);
    run_op(arith_ctrl_pkg::op_div, '1, 32'd1);
    run_op(arith_ctrl_pkg::op_mod, 32'd7, 32'hffff_fff0);
    run_op(arith_ctrl_pkg::op_div, 32'hffff_ffff, 32'h8000_0000);
    run_op(arith_ctrl_pkg::op_mod, 32'hffff_ffff, 32'd3);
  endtask

  task automatic mul_tests();
    arith_types_pkg::word_t a;
    arith_types_pkg::word_t b;
    for (int i = 0; i < 18; i++) begin
      next_word(a);
      next_word(b);
      run_op(arith_ctrl_pkg::op_mul, a, b);
    end
    run_op(arith_ctrl_pkg::op_mul, '1, '1);
    run_op(arith_ctrl_pkg::op_mul, '0, a);
    run_op(arith_ctrl_pkg::op_mul, 32'd1, b);
  endtask

  task automatic sqrt_tests();
    arith_types_pkg::word_t a;
    arith_types_pkg::word_t b;
    run_op(arith_ctrl_pkg::op_sqrt, '0, '0);
    run_op(arith_ctrl_pkg::op_sqrt, 32'd1, '1);
    run_op(arith_ctrl_pkg::op_sqrt, '1, 32'h1234_5678);
    run_op(arith_ctrl_pkg::op_sqrt, 32'hfffe_0001, '0);  // largest square
    for (int i = 0; i < 8; i++) begin
      next_word(a);
      next_word(b);
      a = arith_types_pkg::word_t'(a[15:0]) * arith_types_pkg::word_t'(a[15:0]);
      run_op(arith_ctrl_pkg::op_sqrt, a, b);
      if (a != '0) run_op(arith_ctrl_pkg::op_sqrt, a - 32'd1, b);
    end
    for (int i = 0; i < 8; i++) begin
      next_word(a);
      next_word(b);
      run_op(arith_ctrl_pkg::op_sqrt, a, b);
    end
  endtask

  task automatic busy_start_test();
    arith_types_pkg::word_t a;
    arith_types_pkg::word_t b;
    next_word(a);
    next_word(b);
    issue_op(arith_ctrl_pkg::op_div, a, b >> 8);
    // extra starts land in the middle of the divide
    repeat (6) begin
      next_word(a);
      start     = 1'b1;
      req.op    = arith_ctrl_pkg::op_mul;
      req.left  = a;
      req.right = b;
      @(negedge clk);
    end
    start = 1'b0;
    if (!busy) begin
      failures++;
      $display("ERROR at %0t: busy low while a divide should be running", $time);
    end
    wait_idle();
  endtask

  task automatic mixed_tests();
    arith_types_pkg::word_t w;
    arith_types_pkg::word_t a;
    arith_types_pkg::word_t b;
    for (int i = 0; i < mixed_ops; i++) begin
      next_word(w);
      next_word(a);
      next_word(b);
      if (w[7:4] == 4'd0) b = '0;
      else b = b >> w[12:8];
      run_op(arith_ctrl_pkg::op_e'(w[1:0]), a, b);
    end
  endtask

  initial begin
    rng_state = 32'ha311;
    reset     = 1'b1;
    start     = 1'b0;
    req       = '0;
    repeat (16) @(negedge clk);
    check_reset_values();
    reset = 1'b0;
    @(negedge clk);
    check_reset_values();

    div_mod_tests();
    mul_tests();
    sqrt_tests();
    busy_start_test();
    mixed_tests();

    repeat (4) @(negedge clk);
    if (done_count != accepted || req_fifo.size() != 0) begin
      failures++;
      $display("ERROR: %0d requests accepted but %0d done pulses seen", accepted, done_count);
    end
    print_counts();
    if (mismatches == 0 && failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* sources.f */
design/arith_types_pkg.sv
design/arith_ctrl_pkg.sv
design/seq_divider.sv
design/pipe_multiplier.sv
design/int_sqrt.sv
design/arith_unit.sv
test/arith_unit_checker.sv
test/arith_unit_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := arith_unit_tb
FILELIST := sources.f

OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := *** TEST FAILED ***

SOURCES  := $(shell grep -v '^+' $(FILELIST))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a listed source or the list itself changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF 'TEST PASSED' $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
